//--- logic/eeprom_pkg.sv
package eeprom_pkg;

    localparam int         ADDR_W   = 11;
    localparam int         BLOCK_W  = 3;
    localparam int         WORD_W   = ADDR_W - BLOCK_W; // word address byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // control byte as the memory sees it, msb first on the wire
    typedef struct packed {
        logic [3:0]         dev;
        logic [BLOCK_W-1:0] block;
        logic               rnw;
    } ctrl_fields_t;

    typedef union packed {
        logic [7:0]   raw;   // shifted out as-is
        ctrl_fields_t f;
    } ctrl_byte_u;

    // one host request, latched on the strobe
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
        logic              is_read;
    } eeprom_req_t;

endpackage

//--- logic/i2c_pkg.sv
package i2c_pkg;

    localparam int QUARTERS  = 4; // CLK cycles per SCL period
    localparam int Q_W       = $clog2(QUARTERS);
    localparam int BYTE_BITS = 8;
    localparam int BIT_W     = $clog2(BYTE_BITS + 1); // counts data bits plus ack

    // scl is high in the two middle quarters of a bit
    localparam logic [Q_W-1:0] Q_RISE   = Q_W'(1);
    localparam logic [Q_W-1:0] Q_SAMPLE = Q_W'(2);
    localparam logic [Q_W-1:0] Q_LAST   = Q_W'(QUARTERS - 1);

    typedef enum logic [1:0] {
        op_start,
        op_stop,
        op_write,
        op_read
    } bit_op_e;

    typedef struct packed {
        bit_op_e    op;
        logic [7:0] tx_byte;
        logic       mack;    // 1 pulls SDA low after a read
    } bit_cmd_t;

    typedef struct packed {
        logic [7:0] rx_byte;
        logic       slave_ack;
    } bit_res_t;

endpackage

//--- logic/i2c_bit_engine.sv
module i2c_bit_engine
    import i2c_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     cmd_go,
    input  bit_cmd_t cmd,
    output logic     done,
    output bit_res_t res,
    output logic     engine_busy,
    output logic     scl,
    output logic     sda_pull,
    input  logic     sda_in
);

    logic             active;
    logic [Q_W-1:0]   quarter;
    logic [BIT_W-1:0] bit_cnt;
    logic             scl_idle;   // level held between commands
    bit_op_e          op;
    logic             mack;
    logic [7:0]       shreg;
    logic             sda_smp;
    logic             last_q;
    logic             ack_bit;
    logic             in_cond;

    assign last_q  = (quarter == Q_LAST);
    assign ack_bit = (bit_cnt == BIT_W'(BYTE_BITS)); // ninth bit time
    assign in_cond = active && (op == op_start || op == op_stop);

    // start and stop take one SCL period, bytes take nine
    assign done        = active && last_q && (in_cond || ack_bit);
    assign engine_busy = active;

    assign res.rx_byte   = shreg;
    assign res.slave_ack = ~sda_smp; // slave holds SDA low to acknowledge

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active   <= 1'b0;
            quarter  <= '0;
            bit_cnt  <= '0;
            scl_idle <= 1'b1;
        end else if (cmd_go) begin
            active  <= 1'b1;
            quarter <= '0;
            bit_cnt <= '0;
        end else if (active) begin
            quarter <= quarter + 1'b1; // wraps each bit
            if (last_q) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (done) begin
                active   <= 1'b0;
                scl_idle <= (op == op_stop); // only a stop leaves SCL high
            end
        end
    end

    // command fields and shift path
    always_ff @(posedge CLK) begin
        if (cmd_go) begin
            op    <= cmd.op;
            mack  <= cmd.mack;
            shreg <= cmd.tx_byte;
        end else if (active) begin
            if (quarter == Q_SAMPLE) begin
                sda_smp <= sda_in;
            end
            // the line is shifted back in, so a write echoes its own byte
            if (last_q && !ack_bit && !in_cond) begin
                shreg <= {shreg[6:0], sda_smp};
            end
        end
    end

    always_comb begin
        scl      = scl_idle;
        sda_pull = 1'b0;
        if (active) begin
            scl = (quarter == Q_RISE) || (quarter == Q_SAMPLE) ||
                  (op == op_stop && last_q);
            case (op)
                op_start: sda_pull = (quarter >= Q_SAMPLE);  // falls while SCL high
                op_stop:  sda_pull = (quarter < Q_SAMPLE);   // rises while SCL high
                op_write: sda_pull = !ack_bit && !shreg[7];  // released for slave ack
                default:  sda_pull = ack_bit && mack;        // read
            endcase
        end
    end

    // data bits must stay put while the clock is high
    a_sda_stable: assert property (
        @(posedge CLK) disable iff (RESET)
        $changed(sda_pull) && !in_cond |-> !scl
    ) else $error("sda_pull changed with scl high outside start/stop");

endmodule

//--- logic/eeprom_sequencer.sv
module eeprom_sequencer
    import eeprom_pkg::*, i2c_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              WR,
    input  logic              RD,
    input  logic [ADDR_W-1:0] addr,
    input  logic [7:0]        data_in,
    output logic [7:0]        data_out,
    output logic              ACK,
    output logic              nack_err,
    output logic              busy,
    output logic              cmd_go,
    output bit_cmd_t          cmd,
    input  logic              done,
    input  bit_res_t          res,
    input  logic              engine_busy
);

    typedef enum logic [9:0] {
        idle        = 10'b00_0000_0001,
        write_start = 10'b00_0000_0010,
        ctrl_write  = 10'b00_0000_0100,
        addr_write  = 10'b00_0000_1000,
        data_write  = 10'b00_0001_0000,
        read_start  = 10'b00_0010_0000,
        ctrl_read   = 10'b00_0100_0000,
        data_read   = 10'b00_1000_0000,
        stop        = 10'b01_0000_0000,
        ackn        = 10'b10_0000_0000
    } state_e;

    state_e      state;
    state_e      next_state;
    eeprom_req_t req;
    ctrl_byte_u  ctrl;
    logic        strobe;
    logic        nack;

    assign strobe = WR || RD;

    // slave must acknowledge every byte the master sends
    assign nack = done && !res.slave_ack &&
                  (state inside {ctrl_write, addr_write, data_write, ctrl_read});

    assign ACK  = (state == ackn);
    assign busy = (state != idle);

    assign ctrl.f = '{dev: DEV_CODE, block: req.addr[ADDR_W-1:WORD_W], rnw: state == ctrl_read};

    // step order once the current command is done
    always_comb begin
        case (state)
            write_start: next_state = ctrl_write;
            ctrl_write:  next_state = addr_write;
            addr_write:  next_state = req.is_read ? read_start : data_write;
            read_start:  next_state = ctrl_read;
            ctrl_read:   next_state = data_read;
            stop:        next_state = ackn;
            default:     next_state = stop; // data_write, data_read
        endcase
    end

    // command for the step just entered, sampled by the engine on cmd_go
    always_comb begin
        cmd.op      = op_write;
        cmd.tx_byte = ctrl.raw;
        cmd.mack    = 1'b0; // single byte read ends with a nack
        case (state)
            write_start, read_start: cmd.op = op_start;
            addr_write: cmd.tx_byte = req.addr[WORD_W-1:0];
            data_write: cmd.tx_byte = req.wdata;
            data_read:  cmd.op = op_read;
            stop:       cmd.op = op_stop;
            default:    cmd.tx_byte = ctrl.raw;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= idle;
            cmd_go   <= 1'b0;
            nack_err <= 1'b0;
        end else begin
            cmd_go <= 1'b0;
            case (state)
                idle: begin
                    if (strobe) begin
                        state    <= write_start;
                        cmd_go   <= 1'b1;
                        nack_err <= 1'b0;
                    end
                end
                ackn: state <= idle;
                default: begin
                    if (done) begin
                        state  <= nack ? stop : next_state; // abort straight to stop
                        cmd_go <= (state != stop);
                        if (nack) begin
                            nack_err <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == idle && strobe) begin
            req <= '{addr: addr, wdata: data_in, is_read: RD};
        end
        if (state == data_read && done) begin
            data_out <= res.rx_byte;
        end
    end

    a_one_strobe: assert property (
        @(posedge CLK) disable iff (RESET) !(WR && RD)
    ) else $error("WR and RD high in the same cycle");

    a_ack_pulse: assert property (
        @(posedge CLK) disable iff (RESET) ACK |=> !ACK
    ) else $error("ACK longer than one cycle");

    // engine takes one command at a time
    a_go_idle: assert property (
        @(posedge CLK) disable iff (RESET) cmd_go |-> !engine_busy
    ) else $error("cmd_go while engine busy");

endmodule

//--- logic/eeprom_ctrl_top.sv
module eeprom_ctrl_top
    import eeprom_pkg::*, i2c_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              WR,
    input  logic              RD,
    input  logic [ADDR_W-1:0] addr,
    input  logic [7:0]        data_in,
    output logic [7:0]        data_out,
    output logic              ACK,
    output logic              nack_err,
    output logic              busy,
    output logic              scl,
    output logic              sda_pull, // open drain, high pulls SDA low
    input  logic              sda_in
);

    logic     cmd_go;
    logic     done;
    logic     engine_busy;
    bit_cmd_t cmd;
    bit_res_t res;

    eeprom_sequencer eeprom_sequencer_inst (
        .CLK         (CLK),
        .RESET       (RESET),
        .WR          (WR),
        .RD          (RD),
        .addr        (addr),
        .data_in     (data_in),
        .data_out    (data_out),
        .ACK         (ACK),
        .nack_err    (nack_err),
        .busy        (busy),
        .cmd_go      (cmd_go),
        .cmd         (cmd),
        .done        (done),
        .res         (res),
        .engine_busy (engine_busy)
    );

    i2c_bit_engine i2c_bit_engine_inst (
        .CLK         (CLK),
        .RESET       (RESET),
        .cmd_go      (cmd_go),
        .cmd         (cmd),
        .done        (done),
        .res         (res),
        .engine_busy (engine_busy),
        .scl         (scl),
        .sda_pull    (sda_pull),
        .sda_in      (sda_in)
    );

endmodule

//--- tb/eeprom_mem_model.sv
module eeprom_mem_model
    import eeprom_pkg::*;
(
    input  logic CLK,
    input  logic scl,
    input  logic sda,        // resolved bus line
    input  logic no_ack,     // stay off the bus, as if absent
    output logic sda_pull,
    output int   frame_errs
);

    typedef enum logic [1:0] {
        st_idle,
        st_rx,
        st_tx
    } mstate_e;

    logic [7:0]         mem [2**ADDR_W];
    mstate_e            state;
    logic               scl_r;
    logic               sda_r;
    logic               scl_now;
    logic               sda_now;
    logic               clk_hi;     // scl rose and no condition followed
    logic               bit_val;
    logic [3:0]         bits;
    logic [1:0]         phase;      // ctrl, word address, data, extra
    logic [7:0]         shreg;
    logic [7:0]         tx;
    logic [BLOCK_W-1:0] blk;
    logic [7:0]         word;
    logic [7:0]         wdata;
    logic               write_pend;
    logic               go_tx;
    ctrl_byte_u         cb;

    // erased contents follow the address so a block mixup shows up
    function automatic logic [7:0] erased_byte(input logic [ADDR_W-1:0] a);
        logic [BLOCK_W-1:0] b;
        b = a[ADDR_W-1:WORD_W];
        return a[7:0] ^ {b, b, b[BLOCK_W-1:1]};
    endfunction

    initial begin
        for (int a = 0; a < 2**ADDR_W; a++) begin
            mem[a] = erased_byte(ADDR_W'(a));
        end
        state      = st_idle;
        scl_r      = 1'b1;
        sda_r      = 1'b1;
        clk_hi     = 1'b0;
        bit_val    = 1'b1;
        bits       = 4'd0;
        phase      = 2'd0;
        shreg      = 8'h00;
        tx         = 8'hff;
        blk        = '0;
        word       = 8'h00;
        wdata      = 8'h00;
        write_pend = 1'b0;
        go_tx      = 1'b0;
        cb.raw     = 8'h00;
        sda_pull   = 1'b0;
        frame_errs = 0;
        forever begin
            @(negedge CLK);
            scl_now = scl;
            sda_now = sda;
            if (scl_now && scl_r && sda_now != sda_r) begin
                // start or stop, never in the middle of a byte
                if (state != st_idle && bits != 4'd0) begin
                    frame_errs = frame_errs + 1;
                end
                if (!sda_now) begin
                    state = st_rx;
                    phase = 2'd0;
                end else begin
                    if (write_pend) begin
                        mem[{blk, word}] = wdata; // write cycle finishes at once
                    end
                    state = st_idle;
                end
                write_pend = 1'b0;
                go_tx      = 1'b0;
                bits       = 4'd0;
                clk_hi     = 1'b0;
                sda_pull   = 1'b0;
            end else if (scl_now && !scl_r) begin
                clk_hi  = 1'b1;
                bit_val = sda_now;
            end else if (!scl_now && scl_r && clk_hi) begin
                clk_hi = 1'b0;
                if (state == st_rx && bits < 4'd8) begin
                    shreg = {shreg[6:0], bit_val};
                    bits  = bits + 4'd1;
                    if (bits == 4'd8) begin
                        sda_pull = 1'b1; // ack unless turned down below
                        case (phase)
                            2'd0: begin
                                cb.raw = shreg;
                                if (no_ack || cb.f.dev != DEV_CODE) begin
                                    state    = st_idle;
                                    sda_pull = 1'b0;
                                end else begin
                                    blk   = cb.f.block;
                                    go_tx = cb.f.rnw;
                                end
                            end
                            2'd1: word = shreg;
                            2'd2: begin
                                wdata      = shreg;
                                write_pend = 1'b1;
                            end
                            default: sda_pull = 1'b0; // no page writes
                        endcase
                        phase = phase + 2'd1;
                    end
                end else if (state == st_rx) begin
                    // end of the ack bit
                    sda_pull = 1'b0;
                    bits     = 4'd0;
                    if (go_tx) begin
                        go_tx    = 1'b0;
                        state    = st_tx;
                        tx       = mem[{blk, word}];
                        sda_pull = !tx[7];
                    end
                end else if (state == st_tx) begin
                    bits = bits + 4'd1;
                    if (bits < 4'd8) begin
                        tx       = {tx[6:0], 1'b0};
                        sda_pull = !tx[7];
                    end else if (bits == 4'd8) begin
                        sda_pull = 1'b0; // master ack bit
                    end else begin
                        state = st_idle; // single byte reads only
                        bits  = 4'd0;
                    end
                end
            end
            scl_r = scl_now;
            sda_r = sda_now;
        end
    end

endmodule

//--- tb/tb_eeprom_ctrl.sv
module tb_eeprom_ctrl
    import eeprom_pkg::*;
();

    localparam int          N_TRANS    = 200;
    localparam int          CYCLES_PER = 200;   // longer than a full random read
    localparam int          TIMEOUT    = N_TRANS * CYCLES_PER;
    localparam logic [31:0] SEED       = 32'h2e995bba;

    logic              CLK;
    logic              RESET;
    logic              WR;
    logic              RD;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        data_in;
    logic [7:0]        data_out;
    logic              ACK;
    logic              nack_err;
    logic              busy;
    logic              scl;
    logic              sda_pull;
    logic              sda_in;
    logic              mem_pull;
    logic              no_ack;
    int                frame_errs;
    int                cycles = 0;

    logic [7:0]        ref_mem [2**ADDR_W];
    logic [7:0]        last_rd;
    logic              last_rd_ok;

    // wired-and open drain line
    assign sda_in = !(sda_pull || mem_pull);

    eeprom_ctrl_top eeprom_ctrl_top_inst (
        .CLK      (CLK),
        .RESET    (RESET),
        .WR       (WR),
        .RD       (RD),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out),
        .ACK      (ACK),
        .nack_err (nack_err),
        .busy     (busy),
        .scl      (scl),
        .sda_pull (sda_pull),
        .sda_in   (sda_in)
    );

    eeprom_mem_model mem_model_inst (
        .CLK        (CLK),
        .scl        (scl),
        .sda        (sda_in),
        .no_ack     (no_ack),
        .sda_pull   (mem_pull),
        .frame_errs (frame_errs)
    );

    initial begin
        CLK = 1'b0;
    end

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("TEST FAILED");
            $fatal(1, "timeout, the run did not finish within %0d cycles", TIMEOUT);
        end
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // same erased image the memory starts from
    function automatic logic [7:0] erased_byte(input logic [ADDR_W-1:0] a);
        logic [BLOCK_W-1:0] b;
        b = a[ADDR_W-1:WORD_W];
        return a[7:0] ^ {b, b, b[BLOCK_W-1:1]};
    endfunction

    function automatic eeprom_req_t random_req();
        logic [31:0] r;
        eeprom_req_t q;
        r         = $urandom();
        q.is_read = r[0];
        if (r[1]) begin
            q.addr = r[12:2];
        end else begin
            q.addr = {r[15:13], 5'b0, r[18:16]}; // small pool spread over every block
        end
        q.wdata = r[26:19];
        return q;
    endfunction

    task automatic run_request(input eeprom_req_t q, input logic refuse,
                               input logic late_strobe);
        logic [31:0] r;
        int          extra_at;
        int          waited;
        check_equal(32'(busy), 32'd0, "busy before strobe");
        no_ack  = refuse;
        addr    = q.addr;
        data_in = q.wdata;
        WR      = !q.is_read;
        RD      = q.is_read;
        @(negedge CLK);
        WR      = 1'b0;
        RD      = 1'b0;
        r       = $urandom();
        addr    = r[10:0];   // must already be latched
        data_in = r[18:11];
        check_equal(32'(busy), 32'd1, "busy after strobe");
        extra_at = 1 + int'($urandom() % 30);
        waited   = 0;
        while (!ACK) begin
            if (late_strobe && waited == extra_at) begin
                r       = $urandom();
                WR      = r[0];
                RD      = !r[0];
                addr    = r[11:1];
                data_in = r[19:12];
            end
            @(negedge CLK);
            WR     = 1'b0;
            RD     = 1'b0;
            waited = waited + 1;
        end
        check_equal(32'(busy), 32'd1, "busy in ACK cycle");
        check_equal(32'(nack_err), 32'(refuse), "nack_err at ACK");
        if (refuse) begin
            if (q.is_read && last_rd_ok) begin
                check_equal(32'(data_out), 32'(last_rd), "data_out kept after NACK");
            end
        end else if (q.is_read) begin
            check_equal(32'(data_out), 32'(ref_mem[q.addr]), "read data");
            last_rd    = data_out;
            last_rd_ok = 1'b1;
        end else begin
            ref_mem[q.addr] = q.wdata;
        end
        // one ACK only, and a refused strobe starts nothing
        repeat (4) begin
            @(negedge CLK);
            check_equal(32'(ACK), 32'd0, "extra ACK");
            check_equal(32'(busy), 32'd0, "busy after ACK");
        end
        no_ack = 1'b0;
    endtask

    initial begin
        eeprom_req_t q;
        logic [31:0] r;
        void'($urandom(SEED));
        RESET      = 1'b1;
        WR         = 1'b0;
        RD         = 1'b0;
        addr       = '0;
        data_in    = 8'h00;
        no_ack     = 1'b0;
        last_rd    = 8'h00;
        last_rd_ok = 1'b0;
        for (int a = 0; a < 2**ADDR_W; a++) begin
            ref_mem[a] = erased_byte(ADDR_W'(a));
        end
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        check_equal(32'(ACK), 32'd0, "ACK after reset");
        check_equal(32'(busy), 32'd0, "busy after reset");
        check_equal(32'(nack_err), 32'd0, "nack_err after reset");
        check_equal(32'(sda_pull), 32'd0, "sda_pull after reset");
        check_equal(32'(scl), 32'd1, "scl after reset");
        RESET = 1'b0;
        @(negedge CLK);

        for (int n = 0; n < N_TRANS; n++) begin
            q = random_req();
            r = $urandom();
            run_request(q, r[3:0] == 4'd0, r[7:5] == 3'd0);
        end

        check_equal(32'(frame_errs), 32'd0, "framing errors seen by memory model");
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- tb.f
logic/eeprom_pkg.sv
logic/i2c_pkg.sv
logic/i2c_bit_engine.sv
logic/eeprom_sequencer.sv
logic/eeprom_ctrl_top.sv
tb/eeprom_mem_model.sv
tb/tb_eeprom_ctrl.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_eeprom_ctrl -o sim_eeprom
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/sim_eeprom
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0
